//--- Makefile
VERILATOR ?= verilator
TOP       := edge_job_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Verification failed
PASS_MSG  := Verification passed
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
hw/edge_pkg.sv
hw/edge_span_planner.sv
hw/line_fetcher.sv
hw/edge_unpacker.sv
hw/edge_fifo.sv
hw/edge_job_top.sv
dv/edge_job_assert.sv
dv/edge_job_tb.sv

//--- dv/edge_job_assert.sv
`timescale 1ns/1ps

module edge_job_assert (
	input logic                clock,
	input logic                rstn,
	input logic                vtx_req,
	input logic                vtx_ack,
	input logic                mem_req,
	input logic                mem_ack,
	input logic                edge_req,
	input logic                edge_ack,
	input edge_pkg::edge_job_t edge_job
);

	// Memory request holds until acknowledged
	mem_req_hold: assert property (@(posedge clock) disable iff (!rstn)
		mem_req && !mem_ack |=> mem_req)
		else $error("mem_req dropped before mem_ack");

	edge_job_stable: assert property (@(posedge clock) disable iff (!rstn)
		edge_req && !edge_ack |=> $stable(edge_job))
		else $error("edge_job changed while waiting for edge_ack");

	// Vertex ack only answers a pending request
	vtx_ack_on_req: assert property (@(posedge clock) disable iff (!rstn)
		$rose(vtx_ack) |-> $past(vtx_req))
		else $error("vtx_ack rose without vtx_req");

	// New memory request only once the previous ack is gone
	mem_req_after_ack: assert property (@(posedge clock) disable iff (!rstn)
		$rose(mem_req) |-> !$past(mem_ack))
		else $error("mem_req raised while mem_ack still high");

endmodule

bind edge_job_top edge_job_assert assert_i (
	.clock    (clock),
	.rstn     (rstn),
	.vtx_req  (vtx_req),
	.vtx_ack  (vtx_ack),
	.mem_req  (mem_req),
	.mem_ack  (mem_ack),
	.edge_req (edge_req),
	.edge_ack (edge_ack),
	.edge_job (edge_job)
);

//--- dv/edge_job_tb.sv
`timescale 1ns/1ps

module edge_job_tb;

	localparam int          TIMEOUT   = 20000;
	localparam logic [31:0] SEED      = 32'h5c6e00ad;
	localparam logic [31:0] DATA_MASK = 32'h5a5a0000;

	logic                  clock;
	logic                  rstn;
	edge_pkg::line_addr_t  edge_base;
	logic                  vtx_req;
	edge_pkg::vertex_job_t vtx_job;
	logic                  vtx_ack;
	logic                  mem_req;
	edge_pkg::line_addr_t  mem_addr;
	logic                  mem_ack;
	edge_pkg::line_data_t  mem_data;
	logic                  edge_req;
	edge_pkg::edge_job_t   edge_job;
	logic                  edge_ack;

	logic [31:0]           stim_lfsr;
	logic [31:0]           mem_lfsr;
	logic [31:0]           cons_lfsr;
	edge_pkg::edge_cnt_t   mem_reqs;
	edge_pkg::edge_cnt_t   exp_reqs;
	edge_pkg::edge_job_t   got_q[$];
	edge_pkg::edge_job_t   exp_q[$];
	int                    ack_delay;
	logic                  ack_random;
	int                    errors;
	int                    test_start_errors;
	int                    tests;
	int                    failed_tests;

	edge_job_top #(
		.EDGE_FIFO_DEPTH (16)
	) dut_i (
		.clock     (clock),
		.rstn      (rstn),
		.edge_base (edge_base),
		.vtx_req   (vtx_req),
		.vtx_job   (vtx_job),
		.vtx_ack   (vtx_ack),
		.mem_req   (mem_req),
		.mem_addr  (mem_addr),
		.mem_ack   (mem_ack),
		.mem_data  (mem_data),
		.edge_req  (edge_req),
		.edge_job  (edge_job),
		.edge_ack  (edge_ack)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	//////////////////////////////
	// Random source and references
	//////////////////////////////

	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(inout logic [31:0] s, input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			s = lfsr_next(s);
			v = {v[30:0], s[0]};
		end
	endtask

	function automatic edge_pkg::vertex_job_t make_vertex(input edge_pkg::vertex_id_t v,
			input edge_pkg::edge_idx_t i, input edge_pkg::edge_cnt_t d);
		edge_pkg::vertex_job_t job;
		job.id        = v;
		job.first_idx = i;
		job.degree    = d;
		return job;
	endfunction

	// Entry i+k of the array holds its own global index, masked
	function automatic edge_pkg::edge_job_t expected_edge(input edge_pkg::vertex_id_t v,
			input edge_pkg::edge_idx_t i, input edge_pkg::edge_cnt_t k);
		edge_pkg::edge_job_t e;
		e.id   = k;
		e.src  = v;
		e.dest = (i + edge_pkg::edge_idx_t'(k)) ^ DATA_MASK;
		return e;
	endfunction

	function automatic edge_pkg::edge_cnt_t line_span(input edge_pkg::edge_idx_t i,
			input edge_pkg::edge_cnt_t d);
		edge_pkg::edge_idx_t per_line;
		edge_pkg::edge_idx_t first_line;
		edge_pkg::edge_idx_t last_line;
		per_line = edge_pkg::edge_idx_t'(edge_pkg::LINE_EDGES);
		if (d == '0)
			return '0;
		first_line = i / per_line;
		last_line  = (i + edge_pkg::edge_idx_t'(d) - 32'd1) / per_line;
		return edge_pkg::edge_cnt_t'(last_line - first_line + 32'd1);
	endfunction

	//////////////////////////////
	// Memory and consumer models
	//////////////////////////////

	initial begin : memory_model
		logic [31:0] delay;
		logic [31:0] word;
		int          hold;
		mem_ack  = 1'b0;
		mem_data = '0;
		forever begin
			@(negedge clock);
			if (rstn && mem_req && !mem_ack) begin
				draw_bits(mem_lfsr, 3, delay);
				for (int c = 0; c < int'(delay); c++)
					@(negedge clock);
				for (int j = 0; j < edge_pkg::LINE_EDGES; j++) begin
					word = (32'(mem_addr) - 32'(edge_base)) * 32'd8 + 32'(j);
					mem_data[j*edge_pkg::EDGE_BITS +: edge_pkg::EDGE_BITS] = word ^ DATA_MASK;
				end
				mem_reqs = mem_reqs + 16'd1;
				mem_ack  = 1'b1;
				hold     = 0;
				while (mem_req && hold < TIMEOUT) begin
					@(negedge clock);
					hold++;
				end
				if (mem_req) begin
					$display("Memory model saw mem_req stay high after mem_ack");
					errors++;
				end
				mem_ack = 1'b0;
			end
		end
	end

	initial begin : consumer_model
		logic [31:0] delay;
		int          hold;
		edge_ack = 1'b0;
		forever begin
			@(negedge clock);
			if (rstn && edge_req && !edge_ack) begin
				if (ack_random)
					draw_bits(cons_lfsr, 4, delay);
				else
					delay = 32'(ack_delay);
				for (int c = 0; c < int'(delay); c++)
					@(negedge clock);
				got_q.push_back(edge_job);
				edge_ack = 1'b1;
				hold     = 0;
				while (edge_req && hold < TIMEOUT) begin
					@(negedge clock);
					hold++;
				end
				if (edge_req) begin
					$display("Consumer model saw edge_req stay high after edge_ack");
					errors++;
				end
				edge_ack = 1'b0;
			end
		end
	end

	//////////////////////////////
	// Checks and test helpers
	//////////////////////////////

	task automatic check_edge(input string name, input edge_pkg::edge_job_t expected,
			input edge_pkg::edge_job_t actual);
		if (expected !== actual) begin
			$display("ERROR %s: edge expected id %0d src %0d dest %h, actual id %0d src %0d dest %h",
				name, expected.id, expected.src, expected.dest,
				actual.id, actual.src, actual.dest);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input edge_pkg::edge_cnt_t expected,
			input edge_pkg::edge_cnt_t actual);
		if (expected !== actual) begin
			$display("ERROR %s: memory requests expected %0d, actual %0d",
				name, expected, actual);
			errors++;
		end
	endtask

	task automatic start_test();
		got_q.delete();
		exp_q.delete();
		mem_reqs          = '0;
		exp_reqs          = '0;
		test_start_errors = errors;
	endtask

	task automatic send_vertex(input string name, input edge_pkg::vertex_job_t job);
		int hold;
		for (int k = 0; k < int'(job.degree); k++)
			exp_q.push_back(expected_edge(job.id, job.first_idx, edge_pkg::edge_cnt_t'(k)));
		exp_reqs = exp_reqs + line_span(job.first_idx, job.degree);
		@(negedge clock);
		vtx_job = job;
		vtx_req = 1'b1;
		hold    = 0;
		while (!vtx_ack && hold < TIMEOUT) begin
			@(negedge clock);
			hold++;
		end
		if (!vtx_ack) begin
			$display("%s: vertex %0d was never acknowledged", name, job.id);
			errors++;
		end
		vtx_req = 1'b0;
		hold    = 0;
		while (vtx_ack && hold < TIMEOUT) begin
			@(negedge clock);
			hold++;
		end
		if (vtx_ack) begin
			$display("%s: vtx_ack stayed high after vtx_req dropped", name);
			errors++;
		end
	endtask

	task automatic wait_edges(input string name);
		int hold;
		hold = 0;
		while (got_q.size() < exp_q.size() && hold < TIMEOUT) begin
			@(negedge clock);
			hold++;
		end
		if (got_q.size() < exp_q.size()) begin
			$display("%s: timed out with %0d of %0d edge jobs received",
				name, got_q.size(), exp_q.size());
			errors++;
		end
		// Quiet window so stray extra edges show up
		repeat (20) @(negedge clock);
	endtask

	task automatic finish_test(input string name);
		check_count(name, exp_reqs, mem_reqs);
		if (got_q.size() != exp_q.size()) begin
			$display("%s: expected %0d edge jobs but received %0d",
				name, exp_q.size(), got_q.size());
			errors++;
		end
		for (int k = 0; k < exp_q.size() && k < got_q.size(); k++)
			check_edge(name, exp_q[k], got_q[k]);
		tests++;
		if (errors == test_start_errors) begin
			$display("%s: PASS", name);
		end else begin
			$display("%s: FAIL with %0d errors", name, errors - test_start_errors);
			failed_tests++;
		end
	endtask

	//////////////////////////////
	// Directed tests
	//////////////////////////////

	task automatic aligned_vertex();
		start_test();
		send_vertex("aligned", make_vertex(32'd1, 32'd16, 16'd5));
		wait_edges("aligned");
		finish_test("aligned");
	endtask

	task automatic misaligned_vertex();
		start_test();
		send_vertex("misaligned", make_vertex(32'd2, 32'd5, 16'd20));
		wait_edges("misaligned");
		finish_test("misaligned");
	endtask

	task automatic zero_degree_vertex();
		start_test();
		send_vertex("degree_zero", make_vertex(32'd3, 32'd40, 16'd0));
		repeat (20) @(negedge clock);
		check_count("degree_zero", '0, mem_reqs);
		if (got_q.size() != 0) begin
			$display("degree_zero: an edge job came out for a vertex with no edges");
			errors++;
		end
		// Follower crosses a line boundary
		send_vertex("degree_zero", make_vertex(32'd4, 32'd62, 16'd3));
		wait_edges("degree_zero");
		finish_test("degree_zero");
	endtask

	task automatic slow_consumer();
		start_test();
		ack_random = 1'b1;
		send_vertex("backpressure", make_vertex(32'd5, 32'd3, 16'd40));
		wait_edges("backpressure");
		ack_random = 1'b0;
		finish_test("backpressure");
	endtask

	task automatic vertex_stream();
		logic [31:0] r_idx;
		logic [31:0] r_deg;
		start_test();
		for (int v = 0; v < 10; v++) begin
			draw_bits(stim_lfsr, 8, r_idx);
			draw_bits(stim_lfsr, 5, r_deg);
			send_vertex("stream", make_vertex(32'(100 + v), r_idx,
				edge_pkg::edge_cnt_t'(r_deg % 32'd31)));
		end
		wait_edges("stream");
		finish_test("stream");
	endtask

	initial begin
		rstn         = 1'b0;
		vtx_req      = 1'b0;
		vtx_job      = '0;
		edge_base    = 29'd100;
		stim_lfsr    = SEED;
		mem_lfsr     = SEED;
		cons_lfsr    = SEED;
		mem_reqs     = '0;
		exp_reqs     = '0;
		ack_delay    = 0;
		ack_random   = 1'b0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		repeat (8) @(negedge clock);
		rstn = 1'b1;

		aligned_vertex();
		misaligned_vertex();
		zero_degree_vertex();
		slow_consumer();
		vertex_stream();

		$display("Tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- hw/edge_fifo.sv
`timescale 1ns/1ps

module edge_fifo #(
	parameter int DEPTH = 16
) (
	input  logic                clock,
	input  logic                rstn,
	input  edge_pkg::edge_job_t push_job,
	input  logic                push_valid,
	output logic                push_ready,
	output logic                edge_req,
	output edge_pkg::edge_job_t edge_job,
	input  logic                edge_ack
);

	localparam int AW = $clog2(DEPTH);

	edge_pkg::edge_job_t mem [DEPTH];
	logic [AW:0]         wr_ptr;
	logic [AW:0]         rd_ptr;
	logic                empty;
	logic                full;
	logic                pop;

	// Extra pointer bit tells full from empty
	assign empty      = (wr_ptr == rd_ptr);
	assign full       = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
	assign push_ready = !full;
	assign pop        = edge_req && edge_ack;
	assign edge_job   = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge clock) begin
		if (push_valid && push_ready)
			mem[wr_ptr[AW-1:0]] <= push_job;
	end

	//////////////////////////////
	// Pointers and output side
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			edge_req <= 1'b0;
		end else begin
			if (push_valid && push_ready)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop) begin
				rd_ptr   <= rd_ptr + 1'b1;
				edge_req <= 1'b0;
			end else if (!edge_req && !edge_ack && !empty) begin
				// Previous ack must be gone first
				edge_req <= 1'b1;
			end
		end
	end

endmodule

//--- hw/edge_job_top.sv
`timescale 1ns/1ps

module edge_job_top #(
	parameter int EDGE_FIFO_DEPTH = 16
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  edge_pkg::line_addr_t  edge_base,
	input  logic                  vtx_req,
	input  edge_pkg::vertex_job_t vtx_job,
	output logic                  vtx_ack,
	output logic                  mem_req,
	output edge_pkg::line_addr_t  mem_addr,
	input  logic                  mem_ack,
	input  edge_pkg::line_data_t  mem_data,
	output logic                  edge_req,
	output edge_pkg::edge_job_t   edge_job,
	input  logic                  edge_ack
);

	edge_pkg::segment_t   seg;
	logic                 seg_valid;
	logic                 seg_ready;
	edge_pkg::line_beat_t beat;
	logic                 beat_valid;
	logic                 beat_ready;
	edge_pkg::edge_job_t  push_job;
	logic                 push_valid;
	logic                 push_ready;

	//////////////////////////////
	// Pipeline stages
	//////////////////////////////

	edge_span_planner planner_i (
		.clock     (clock),
		.rstn      (rstn),
		.edge_base (edge_base),
		.vtx_req   (vtx_req),
		.vtx_job   (vtx_job),
		.vtx_ack   (vtx_ack),
		.seg       (seg),
		.seg_valid (seg_valid),
		.seg_ready (seg_ready)
	);

	// Sole owner of the memory port
	line_fetcher fetcher_i (
		.clock      (clock),
		.rstn       (rstn),
		.seg        (seg),
		.seg_valid  (seg_valid),
		.seg_ready  (seg_ready),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_ack    (mem_ack),
		.mem_data   (mem_data),
		.beat       (beat),
		.beat_valid (beat_valid),
		.beat_ready (beat_ready)
	);

	edge_unpacker unpacker_i (
		.clock      (clock),
		.rstn       (rstn),
		.beat       (beat),
		.beat_valid (beat_valid),
		.beat_ready (beat_ready),
		.push_job   (push_job),
		.push_valid (push_valid),
		.push_ready (push_ready)
	);

	edge_fifo #(
		.DEPTH (EDGE_FIFO_DEPTH)
	) fifo_i (
		.clock      (clock),
		.rstn       (rstn),
		.push_job   (push_job),
		.push_valid (push_valid),
		.push_ready (push_ready),
		.edge_req   (edge_req),
		.edge_job   (edge_job),
		.edge_ack   (edge_ack)
	);

endmodule

//--- hw/edge_pkg.sv
package edge_pkg;

	//////////////////////////////
	// Array and line geometry
	//////////////////////////////

	localparam int EDGE_BITS  = 32;
	localparam int LINE_EDGES = 8;
	localparam int LANE_BITS  = 3;

	typedef logic [31:0]                       vertex_id_t;
	typedef logic [15:0]                       edge_cnt_t;
	typedef logic [31:0]                       edge_idx_t;
	typedef logic [28:0]                       line_addr_t;
	typedef logic [LANE_BITS-1:0]              lane_t;
	typedef logic [3:0]                        seg_cnt_t;
	typedef logic [LINE_EDGES*EDGE_BITS-1:0]   line_data_t;

	//////////////////////////////
	// Job and pipeline payloads
	//////////////////////////////

	typedef struct packed {
		vertex_id_t id;
		edge_idx_t  first_idx;
		edge_cnt_t  degree;
	} vertex_job_t;

	typedef struct packed {
		edge_cnt_t              id;
		vertex_id_t             src;
		logic [EDGE_BITS-1:0]   dest;
	} edge_job_t;

	// One line worth of wanted entries
	typedef struct packed {
		line_addr_t addr;
		lane_t      lane;
		seg_cnt_t   count;
		vertex_id_t src;
		edge_cnt_t  first_id;
	} segment_t;

	typedef struct packed {
		segment_t   seg;
		line_data_t data;
	} line_beat_t;

	typedef enum logic [1:0] {IDLE, PLAN, ACK_WAIT} planner_state_t;
	typedef enum logic [1:0] {READY, REQ, ACK_LOW} fetch_state_t;

endpackage

//--- hw/edge_span_planner.sv
`timescale 1ns/1ps

module edge_span_planner (
	input  logic                  clock,
	input  logic                  rstn,
	input  edge_pkg::line_addr_t  edge_base,
	input  logic                  vtx_req,
	input  edge_pkg::vertex_job_t vtx_job,
	output logic                  vtx_ack,
	output edge_pkg::segment_t    seg,
	output logic                  seg_valid,
	input  logic                  seg_ready
);

	edge_pkg::planner_state_t state;
	edge_pkg::edge_idx_t      idx_q;
	edge_pkg::edge_cnt_t      remain_q;
	edge_pkg::edge_cnt_t      next_id_q;
	edge_pkg::vertex_id_t     src_q;
	edge_pkg::lane_t          start_lane;
	edge_pkg::seg_cnt_t       room;
	edge_pkg::seg_cnt_t       seg_count;
	logic                     seg_fire;
	logic                     last_seg;

	//////////////////////////////
	// Segment shaping
	//////////////////////////////

	// Entries left in the current line from the start lane on
	assign start_lane = idx_q[edge_pkg::LANE_BITS-1:0];
	assign room       = edge_pkg::seg_cnt_t'(edge_pkg::LINE_EDGES) - edge_pkg::seg_cnt_t'(start_lane);
	assign seg_count  = (remain_q < edge_pkg::edge_cnt_t'(room)) ?
		edge_pkg::seg_cnt_t'(remain_q) : room;

	assign seg.addr     = edge_base + edge_pkg::line_addr_t'(idx_q >> edge_pkg::LANE_BITS);
	assign seg.lane     = start_lane;
	assign seg.count    = seg_count;
	assign seg.src      = src_q;
	assign seg.first_id = next_id_q;

	assign seg_valid = (state == edge_pkg::PLAN);
	assign seg_fire  = seg_valid && seg_ready;
	assign last_seg  = (remain_q == edge_pkg::edge_cnt_t'(seg_count));

	//////////////////////////////
	// Vertex handshake FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state   <= edge_pkg::IDLE;
			vtx_ack <= 1'b0;
		end else begin
			case (state)
				edge_pkg::IDLE: begin
					if (vtx_req) begin
						vtx_ack <= 1'b1;
						// Degree zero goes straight to the release phase
						state   <= (vtx_job.degree == '0) ? edge_pkg::ACK_WAIT : edge_pkg::PLAN;
					end
				end
				edge_pkg::PLAN: begin
					if (seg_fire && last_seg)
						state <= edge_pkg::ACK_WAIT;
				end
				edge_pkg::ACK_WAIT: begin
					if (!vtx_req) begin
						vtx_ack <= 1'b0;
						state   <= edge_pkg::IDLE;
					end
				end
				default: state <= edge_pkg::IDLE;
			endcase
		end
	end

	// Job capture and per-segment advance
	always_ff @(posedge clock) begin
		if (state == edge_pkg::IDLE && vtx_req) begin
			idx_q     <= vtx_job.first_idx;
			remain_q  <= vtx_job.degree;
			next_id_q <= '0;
			src_q     <= vtx_job.id;
		end else if (seg_fire) begin
			idx_q     <= idx_q + edge_pkg::edge_idx_t'(seg_count);
			remain_q  <= remain_q - edge_pkg::edge_cnt_t'(seg_count);
			next_id_q <= next_id_q + edge_pkg::edge_cnt_t'(seg_count);
		end
	end

endmodule

//--- hw/edge_unpacker.sv
`timescale 1ns/1ps

module edge_unpacker (
	input  logic                 clock,
	input  logic                 rstn,
	input  edge_pkg::line_beat_t beat,
	input  logic                 beat_valid,
	output logic                 beat_ready,
	output edge_pkg::edge_job_t  push_job,
	output logic                 push_valid,
	input  logic                 push_ready
);

	edge_pkg::line_beat_t beat_q;
	edge_pkg::lane_t      cursor;
	edge_pkg::seg_cnt_t   emitted;
	logic                 busy;
	logic                 take_beat;
	logic                 push_fire;
	logic                 last_lane;

	//////////////////////////////
	// Lane selection
	//////////////////////////////

	assign beat_ready = !busy;
	assign take_beat  = beat_valid && beat_ready;
	assign push_valid = busy;
	assign push_fire  = push_valid && push_ready;
	assign last_lane  = (edge_pkg::seg_cnt_t'(emitted + 1'b1) == beat_q.seg.count);

	// Lane 0 sits in the low bits of the line
	assign push_job.id   = beat_q.seg.first_id + edge_pkg::edge_cnt_t'(emitted);
	assign push_job.src  = beat_q.seg.src;
	assign push_job.dest = beat_q.data[edge_pkg::EDGE_BITS*cursor +: edge_pkg::EDGE_BITS];

	//////////////////////////////
	// Walk control
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy <= 1'b0;
		end else begin
			if (take_beat)
				busy <= 1'b1;
			else if (push_fire && last_lane)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (take_beat) begin
			beat_q  <= beat;
			// Skip lanes before the segment start
			cursor  <= beat.seg.lane;
			emitted <= '0;
		end else if (push_fire) begin
			cursor  <= cursor + 1'b1;
			emitted <= emitted + 1'b1;
		end
	end

endmodule

//--- hw/line_fetcher.sv
`timescale 1ns/1ps

module line_fetcher (
	input  logic                 clock,
	input  logic                 rstn,
	input  edge_pkg::segment_t   seg,
	input  logic                 seg_valid,
	output logic                 seg_ready,
	output logic                 mem_req,
	output edge_pkg::line_addr_t mem_addr,
	input  logic                 mem_ack,
	input  edge_pkg::line_data_t mem_data,
	output edge_pkg::line_beat_t beat,
	output logic                 beat_valid,
	input  logic                 beat_ready
);

	edge_pkg::fetch_state_t state;
	edge_pkg::segment_t     seg_q;

	assign seg_ready = (state == edge_pkg::READY);
	assign mem_addr  = seg_q.addr;

	//////////////////////////////
	// Memory handshake FSM
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state      <= edge_pkg::READY;
			mem_req    <= 1'b0;
			beat_valid <= 1'b0;
		end else begin
			// Beat leaves once the unpacker takes it
			if (beat_valid && beat_ready)
				beat_valid <= 1'b0;

			case (state)
				edge_pkg::READY: begin
					if (seg_valid) begin
						mem_req <= 1'b1;
						state   <= edge_pkg::REQ;
					end
				end
				edge_pkg::REQ: begin
					if (mem_ack) begin
						mem_req    <= 1'b0;
						beat_valid <= 1'b1;
						state      <= edge_pkg::ACK_LOW;
					end
				end
				edge_pkg::ACK_LOW: begin
					// Both ack release and beat hand-off before next segment
					if (!mem_ack && (!beat_valid || beat_ready))
						state <= edge_pkg::READY;
				end
				default: state <= edge_pkg::READY;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (seg_ready && seg_valid)
			seg_q <= seg;
		if (state == edge_pkg::REQ && mem_ack) begin
			beat.seg  <= seg_q;
			beat.data <= mem_data;
		end
	end

endmodule
